//--- fix_to_float_top.f
rtl/fix_to_float_pkg.sv
rtl/byte_data_mem.sv
rtl/leading_one_norm.sv
rtl/half_float_pack.sv
rtl/conv_sequencer.sv
rtl/fix_to_float_top.sv
testbench/fix_to_float_tb.sv

//--- rtl/byte_data_mem.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte wide data memory with a host port and an engine port
// both ports read and write synchronously, engine write wins
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module byte_data_mem #(
  parameter int addr_w = 8                                   // address bits
) (
  input  wire logic                                clk,
  // host side, loads operands and fetches results
  input  wire logic [addr_w-1:0]                   host_addr,
  input  wire logic                                host_wr_en,
  input  wire logic [fix_to_float_pkg::byte_w-1:0] host_wr_data,
  output      logic [fix_to_float_pkg::byte_w-1:0] host_rd_data,
  // engine side, driven by the sequencer
  input  wire logic [addr_w-1:0]                   eng_addr,
  input  wire logic                                eng_wr_en,
  input  wire logic [fix_to_float_pkg::byte_w-1:0] eng_wr_data,
  output      logic [fix_to_float_pkg::byte_w-1:0] eng_rd_data
);

  import fix_to_float_pkg::*;

  localparam int depth = 2 ** addr_w;                        // one byte per address

  logic [byte_w-1:0] mem_core [depth];                       // storage, no reset

  // writes from both ports in one process
  // engine write comes last so it overrides a host write to the same byte
  always_ff @(posedge clk) begin
    if (host_wr_en) begin
      mem_core[host_addr] <= host_wr_data;                   // host load
    end
    if (eng_wr_en) begin
      mem_core[eng_addr] <= eng_wr_data;                     // engine result
    end
  end

  // registered reads, data one cycle after address
  always_ff @(posedge clk) begin
    host_rd_data <= mem_core[host_addr];                     // old data on same-cycle write
    eng_rd_data  <= mem_core[eng_addr];
  end

endmodule

`default_nettype wire

//--- rtl/conv_sequencer.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// conversion FSM: reads the two operand bytes, launches the
// packer, writes the two result bytes and drives done
// done drops on the start edge and rises seven edges later
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module conv_sequencer #(
  parameter int addr_w   = 8,                                // memory address bits
  parameter int src_addr = 0,                                // operand low byte
  parameter int dst_addr = 2                                 // result low byte
) (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic                                start,    // sampled only in idle
  output      logic                                done,
  // engine port of the data memory
  output      logic [addr_w-1:0]                   eng_addr,
  output      logic                                eng_wr_en,
  output      logic [fix_to_float_pkg::byte_w-1:0] eng_wr_data,
  input  wire logic [fix_to_float_pkg::byte_w-1:0] eng_rd_data,
  // packer handoff
  output      logic [fix_to_float_pkg::fix_w-1:0]  fix_in,
  output      logic                                pack_en,
  input  wire logic [fix_to_float_pkg::fix_w-1:0]  float_out
);

  import fix_to_float_pkg::*;

  localparam logic [addr_w-1:0] src_lo = addr_w'(src_addr);
  localparam logic [addr_w-1:0] src_hi = addr_w'(src_addr + 1);
  localparam logic [addr_w-1:0] dst_lo = addr_w'(dst_addr);
  localparam logic [addr_w-1:0] dst_hi = addr_w'(dst_addr + 1);

  seq_state_t       state;
  seq_state_t       state_next;
  logic [fix_w-1:0] operand;                                 // assembled 8.8 value

  // fixed walk, no branches once started
  always_comb begin
    state_next = state;
    case (state)
      idle:    if (start) state_next = rd_lo;                // busy starts ignore start
      rd_lo:   state_next = rd_hi;
      rd_hi:   state_next = capture;
      capture: state_next = pack;
      pack:    state_next = wr_lo;
      wr_lo:   state_next = wr_hi;
      wr_hi:   state_next = finish;
      finish:  state_next = idle;
      default: state_next = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // done stays low after reset until a conversion completes
  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
    end else if (state == idle && start) begin
      done <= 1'b0;                                          // falls on the start edge
    end else if (state == finish) begin
      done <= 1'b1;                                          // seven edges after start
    end
  end

  // read data lags the address by one cycle
  // so low byte lands during rd_hi, high byte during capture
  always_ff @(posedge clk) begin
    if (state == rd_hi) begin
      operand[byte_w-1:0] <= eng_rd_data;
    end
    if (state == capture) begin
      operand[fix_w-1:byte_w] <= eng_rd_data;
    end
  end

  assign fix_in  = operand;
  assign pack_en = (state == pack);                          // packer registers on this edge

  // address, write enable and write data per state
  always_comb begin
    eng_addr    = src_lo;
    eng_wr_en   = 1'b0;
    eng_wr_data = float_out[byte_w-1:0];
    case (state)
      rd_hi: eng_addr = src_hi;
      wr_lo: begin
        eng_addr  = dst_lo;
        eng_wr_en = 1'b1;                                    // low result byte
      end
      wr_hi: begin
        eng_addr    = dst_hi;
        eng_wr_en   = 1'b1;
        eng_wr_data = float_out[fix_w-1:byte_w];             // sign and upper exponent
      end
      default: eng_addr = src_lo;
    endcase
  end

endmodule

`default_nettype wire

//--- rtl/fix_to_float_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared widths, float fields and sequencer states for the
// fixed 8.8 to half-precision conversion engine
// modules pull these in with a wildcard import in their body
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package fix_to_float_pkg;

  // fixed point operand
  localparam int fix_w     = 16;              // signed 8.8 word, also float width
  localparam int frac_bits = 8;               // bits right of the binary point

  // half float fields
  localparam int exp_w     = 5;               // exponent field
  localparam int man_w     = 10;              // stored mantissa, hidden one dropped
  localparam int exp_bias  = 15;              // ieee half bias

  // data memory
  localparam int byte_w    = 8;               // memory word

  // conversion FSM, one state per clock
  typedef enum logic [2:0] {
    idle,                                     // waiting for start
    rd_lo,                                    // operand low byte address out
    rd_hi,                                    // high byte address, low byte back
    capture,                                  // high byte back
    pack,                                     // pulse to the packer
    wr_lo,                                    // result low byte to memory
    wr_hi,                                    // result high byte to memory
    finish                                    // raise done next edge
  } seq_state_t;

endpackage

`default_nettype wire

//--- rtl/fix_to_float_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// top level of the 8.8 to half float engine
// host loads bytes 0 and 1, pulses start, waits for done,
// then reads the result from bytes 2 and 3
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fix_to_float_top #(
  parameter int addr_w   = 8,                                // memory depth is 2**addr_w
  parameter int src_addr = 0,                                // operand base
  parameter int dst_addr = 2                                 // result base
) (
  input  wire logic                                clk,
  input  wire logic                                reset,
  input  wire logic                                start,
  output      logic                                done,
  input  wire logic [addr_w-1:0]                   host_addr,
  input  wire logic                                host_wr_en,
  input  wire logic [fix_to_float_pkg::byte_w-1:0] host_wr_data,
  output      logic [fix_to_float_pkg::byte_w-1:0] host_rd_data
);

  import fix_to_float_pkg::*;

  // engine port of the memory
  logic [addr_w-1:0] eng_addr;
  logic              eng_wr_en;
  logic [byte_w-1:0] eng_wr_data;
  logic [byte_w-1:0] eng_rd_data;

  // sequencer to packer
  logic [fix_w-1:0]  fix_in;
  logic              pack_en;
  logic [fix_w-1:0]  float_out;

  byte_data_mem #(
    .addr_w (addr_w)
  ) u_mem (
    .clk          (clk),
    .host_addr    (host_addr),
    .host_wr_en   (host_wr_en),
    .host_wr_data (host_wr_data),
    .host_rd_data (host_rd_data),
    .eng_addr     (eng_addr),
    .eng_wr_en    (eng_wr_en),
    .eng_wr_data  (eng_wr_data),
    .eng_rd_data  (eng_rd_data)
  );

  conv_sequencer #(
    .addr_w   (addr_w),
    .src_addr (src_addr),
    .dst_addr (dst_addr)
  ) u_seq (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .done        (done),
    .eng_addr    (eng_addr),
    .eng_wr_en   (eng_wr_en),
    .eng_wr_data (eng_wr_data),
    .eng_rd_data (eng_rd_data),
    .fix_in      (fix_in),
    .pack_en     (pack_en),
    .float_out   (float_out)
  );

  // one cycle from pack_en to float_out
  half_float_pack u_pack (
    .clk       (clk),
    .reset     (reset),
    .pack_en   (pack_en),
    .fix_in    (fix_in),
    .float_out (float_out)
  );

endmodule

`default_nettype wire

//--- rtl/half_float_pack.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// splits a signed 8.8 value into sign and magnitude, runs
// the normalizer and registers the packed half float on pack_en
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module half_float_pack (
  input  wire logic                               clk,
  input  wire logic                               reset,
  input  wire logic                               pack_en,   // one cycle launch
  input  wire logic [fix_to_float_pkg::fix_w-1:0] fix_in,    // signed 8.8 operand
  output      logic [fix_to_float_pkg::fix_w-1:0] float_out  // sign, exponent, mantissa
);

  import fix_to_float_pkg::*;

  logic             sign;                                    // two's comp msb
  logic [fix_w-1:0] mag;                                     // absolute value
  logic [exp_w-1:0] norm_exp;
  logic [man_w-1:0] norm_man;
  logic             norm_zero;

  assign sign = fix_in[fix_w-1];                             // same bit serves as float sign

  // negate when negative
  // 0x8000 wraps to itself, taken as unsigned 32768
  assign mag = sign ? (~fix_in + 1'b1) : fix_in;

  leading_one_norm u_norm (
    .mag     (mag),
    .exp_out (norm_exp),
    .man_out (norm_man),
    .is_zero (norm_zero)
  );

  // single cycle latency, result held until next launch
  always_ff @(posedge clk) begin
    if (reset) begin
      float_out <= '0;
    end else if (pack_en) begin
      if (norm_zero) begin
        float_out <= '0;                                     // positive zero
      end else begin
        float_out <= {sign, norm_exp, norm_man};             // 1 + 5 + 10 bits
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/leading_one_norm.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// combinational normalizer for an unsigned fixed magnitude
// finds the leading one, forms biased exponent and mantissa
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module leading_one_norm (
  input  wire logic [fix_to_float_pkg::fix_w-1:0] mag,       // unsigned magnitude
  output      logic [fix_to_float_pkg::exp_w-1:0] exp_out,   // biased exponent
  output      logic [fix_to_float_pkg::man_w-1:0] man_out,   // fraction after hidden one
  output      logic                               is_zero    // magnitude was zero
);

  import fix_to_float_pkg::*;

  localparam int pos_w      = $clog2(fix_w);                 // bit index width
  localparam int exp_offset = exp_bias - frac_bits;          // 7 for 8.8 into half

  logic [pos_w-1:0] lead_pos;                                // index of highest one
  logic             found;                                   // any one seen
  logic [pos_w-1:0] shift_amt;                               // left shift to align
  logic [fix_w-1:0] aligned;                                 // leading one at msb
  logic [exp_w-1:0] exp_sum;

  // priority search from the msb down
  always_comb begin
    lead_pos = '0;
    found    = 1'b0;
    for (int i = fix_w - 1; i >= 0; i--) begin
      if (!found && mag[i]) begin
        lead_pos = pos_w'(i);                                // first hit is the highest
        found    = 1'b1;
      end
    end
  end

  assign is_zero = ~found;                                   // no bit set at all

  // push the leading one up to bit fix_w-1
  assign shift_amt = pos_w'(fix_w - 1) - lead_pos;
  assign aligned   = mag << shift_amt;                       // zeros shifted in below

  // position 15 gives 22, position 0 gives 7
  assign exp_sum = exp_w'(lead_pos) + exp_w'(exp_offset);

  // hidden one dropped, next man_w bits kept, the rest truncated
  always_comb begin
    if (is_zero) begin
      exp_out = '0;                                          // zero encodes as all zeros
      man_out = '0;
    end else begin
      exp_out = exp_sum;
      man_out = aligned[fix_w-2 -: man_w];                   // no rounding
    end
  end

endmodule

`default_nettype wire

//--- testbench/fix_to_float_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the 8.8 to half float engine
// loads operands over the host port, pulses start, waits for
// done and compares bytes 2 and 3 against a reference model
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module fix_to_float_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int addr_w       = 8;
  localparam int reset_cycles = 5;
  localparam int num_conv     = 49;                          // 2 + 3 + 2 + 2 + 40
  localparam int done_edges   = 7;                           // start edge to done edge
  localparam int done_wait    = 20;                          // give up on done after this
  localparam int cycle_limit  = num_conv * 30 + reset_cycles + 20;

  logic              clk;
  logic              reset;
  logic              start;
  logic              done;
  logic [addr_w-1:0] host_addr;
  logic              host_wr_en;
  logic [7:0]        host_wr_data;
  logic [7:0]        host_rd_data;

  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;
  logic [15:0] lfsr_state;

  fix_to_float_top #(
    .addr_w   (addr_w),
    .src_addr (0),
    .dst_addr (2)
  ) dut (
    .clk          (clk),
    .reset        (reset),
    .start        (start),
    .done         (done),
    .host_addr    (host_addr),
    .host_wr_en   (host_wr_en),
    .host_wr_data (host_wr_data),
    .host_rd_data (host_rd_data)
  );

  always #10 clk = ~clk;                                     // 20 ns period

  // hard stop if something never finishes
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: simulation ran past %0d cycles", cycle_limit);
      $display("Some tests failed");
      $finish;
    end
  end

  // galois lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end else begin
      return s >> 1;
    end
  endfunction

  // one step per bit taken
  function automatic logic [15:0] random_word();
    logic [15:0] word;
    word = '0;
    for (int i = 0; i < 16; i++) begin
      word       = {word[14:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return word;
  endfunction

  // abs value, leading one position plus 7, next 10 bits truncated
  function automatic logic [15:0] reference_convert(input logic [15:0] value);
    logic sign;
    int   mag;
    int   lead;
    int   expo;
    int   man;
    sign = value[15];
    mag  = sign ? 65536 - int'(value) : int'(value);         // 0x8000 stays 32768
    if (mag == 0) begin
      return 16'h0000;
    end
    lead = 0;
    for (int i = 0; i < 17; i++) begin
      if ((mag >> i) != 0) begin
        lead = i;                                            // ends at the highest one
      end
    end
    expo = lead - 8 + 15;                                    // undo 8 fraction bits, add bias
    man  = ((mag << 10) >> lead) & 'h3FF;                    // hidden one lands on bit 10
    return {sign, expo[4:0], man[9:0]};
  endfunction

  task automatic check_value(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, expected);
    end
  endtask

  // tasks below start and end just after a falling edge
  task automatic write_byte(input logic [addr_w-1:0] addr, input logic [7:0] data);
    host_addr    = addr;
    host_wr_data = data;
    host_wr_en   = 1'b1;
    @(negedge clk);                                          // written on the rising edge
    host_wr_en   = 1'b0;
  endtask

  task automatic read_byte(input logic [addr_w-1:0] addr, output logic [7:0] data);
    host_addr  = addr;
    host_wr_en = 1'b0;
    @(negedge clk);                                          // one cycle read latency
    data = host_rd_data;
  endtask

  // load, start, wait for done, check timing and both result bytes
  // restart_at puts a second start pulse that many edges into the run
  task automatic run_conversion(input logic [15:0] operand, input logic [15:0] expected,
                                input int restart_at);
    logic [7:0] lo;
    logic [7:0] hi;
    int         edges;
    write_byte(0, operand[7:0]);
    write_byte(1, operand[15:8]);
    start = 1'b1;
    @(negedge clk);                                          // start edge in between
    start = 1'b0;
    check_value("done", done, 1'b0);                         // low right after start edge
    edges = 0;
    while (done !== 1'b1 && edges < done_wait) begin
      if (edges == restart_at) begin
        start = 1'b1;                                        // should be ignored
      end
      @(negedge clk);
      start = 1'b0;
      edges++;
    end
    if (done !== 1'b1) begin
      errors++;
      $display("done never rose within %0d cycles for operand 0x%h", done_wait, operand);
    end
    check_value("done_edges", edges, done_edges);
    read_byte(2, lo);
    read_byte(3, hi);
    check_value("result", {hi, lo}, expected);
    check_value("done", done, 1'b1);                         // no restart slipped in
  endtask

  task automatic zero_and_one();
    logic [7:0] data;
    check_value("done", done, 1'b0);                         // idle after reset
    write_byte(0, 8'h5A);
    write_byte(1, 8'hC3);
    read_byte(0, data);
    check_value("host_rd_data", data, 8'h5A);
    read_byte(1, data);
    check_value("host_rd_data", data, 8'hC3);
    run_conversion(16'h0000, 16'h0000, -1);
    run_conversion(16'h0100, 16'h3C00, -1);                  // 1.0
  endtask

  task automatic range_ends();
    run_conversion(16'h0001, 16'h1C00, -1);                  // smallest step
    run_conversion(16'h7FFF, 16'h57FF, -1);                  // truncated, not rounded
    run_conversion(16'h0180, 16'h3E00, -1);                  // 1.5
  endtask

  task automatic negative_inputs();
    run_conversion(16'hFF00, 16'hBC00, -1);                  // -1.0
    run_conversion(16'h8000, 16'hD800, -1);                  // most negative
  endtask

  task automatic start_timing();
    run_conversion(16'h0340, 16'h4280, 2);                   // 3.25, restart mid run
    run_conversion(16'hFD80, 16'hC100, 6);                   // -2.5, restart in finish
  endtask

  task automatic random_sweep();
    logic [15:0] operand;
    logic [7:0]  data;
    operand = '0;
    for (int n = 0; n < 40; n++) begin
      operand = random_word();
      run_conversion(operand, reference_convert(operand), -1);
    end
    read_byte(0, data);                                      // engine left operand alone
    check_value("host_rd_data", data, operand[7:0]);
    read_byte(1, data);
    check_value("host_rd_data", data, operand[15:8]);
  endtask

  initial begin
    clk          = 1'b0;
    reset        = 1'b1;
    start        = 1'b0;
    host_addr    = '0;
    host_wr_en   = 1'b0;
    host_wr_data = '0;
    lfsr_state   = 16'd18;                                   // seed
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    zero_and_one();
    range_ends();
    negative_inputs();
    start_timing();
    random_sweep();
    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
